/* common/rv_exec_defs.svh */
`ifndef RV_EXEC_DEFS_SVH
`define RV_EXEC_DEFS_SVH

// ----------------------------------------
// data path widths
// ----------------------------------------
`define XLEN        32
`define REG_ADDR_W  5
`define SHAMT_W     5   // low bits of rs2 / imm used for shifts

// ----------------------------------------
// ISA constants
// ----------------------------------------
`define PC_STEP     4   // sequential instruction size in bytes

// significant immediate bits per format
`define IMM_I_W     12
`define IMM_B_W     13
`define IMM_J_W     21

`endif

/* common/rv_exec_pkg.sv */
`include "rv_exec_defs.svh"

package rv_exec_pkg;

  typedef logic [`XLEN-1:0]       word_t;     // data, address or pc
  typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
  typedef logic [`SHAMT_W-1:0]    shamt_t;

  // one literal per supported instruction
  typedef enum logic [4:0] {
    OP_ADD,
    OP_SUB,
    OP_SLT,
    OP_SLTU,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_ADDI,
    OP_SLTI,
    OP_SLTIU,
    OP_ANDI,
    OP_ORI,
    OP_XORI,
    OP_SLLI,
    OP_SRLI,
    OP_SRAI,
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_BEQ,
    OP_BNE,
    OP_BLT,
    OP_BGE,
    OP_BLTU,
    OP_BGEU,
    OP_LW,
    OP_SW
  } exec_op_t;

  // data bus sequencing
  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_REQ,   // request up, waiting for ack
    LSU_REL,   // request down, waiting for ack release
    LSU_DONE
  } lsu_state_t;

endpackage

/* source/rv_operand_sel.sv */
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_operand_sel (
  input  rv_exec_pkg::exec_op_t op,
  input  rv_exec_pkg::word_t    imm,
  input  rv_exec_pkg::word_t    rs2_val,
  output rv_exec_pkg::word_t    imm_ext,
  output rv_exec_pkg::word_t    op_b
);
  import rv_exec_pkg::*;

  word_t imm_i;
  word_t imm_b;
  word_t imm_j;

  // sign extension of the significant field per format
  assign imm_i = {{(`XLEN-`IMM_I_W){imm[`IMM_I_W-1]}}, imm[`IMM_I_W-1:0]};
  assign imm_b = {{(`XLEN-`IMM_B_W){imm[`IMM_B_W-1]}}, imm[`IMM_B_W-1:0]};
  assign imm_j = {{(`XLEN-`IMM_J_W){imm[`IMM_J_W-1]}}, imm[`IMM_J_W-1:0]};

  always_comb begin
    case (op)
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: imm_ext = imm_b;
      OP_JAL:           imm_ext = imm_j;
      OP_LUI, OP_AUIPC: imm_ext = imm;  // U format as given
      default:          imm_ext = imm_i;  // I and S
    endcase
  end

  // ----------------------------------------
  // second ALU operand
  // ----------------------------------------
  always_comb begin
    case (op)
      OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND,
      OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA: op_b = rs2_val;
      default:                                op_b = imm_ext;
    endcase
  end

endmodule

/* alu/rv_alu.sv */
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_alu (
  input  rv_exec_pkg::exec_op_t op,
  input  rv_exec_pkg::word_t    op_a,
  input  rv_exec_pkg::word_t    op_b,
  output rv_exec_pkg::word_t    result
);
  import rv_exec_pkg::*;

  word_t  sum;
  word_t  diff;
  shamt_t shamt;
  logic   lt_s;
  logic   lt_u;

  assign sum   = op_a + op_b;
  assign diff  = op_a - op_b;
  assign shamt = op_b[`SHAMT_W-1:0];  // upper bits ignored, SRA included
  assign lt_s  = $signed(op_a) < $signed(op_b);
  assign lt_u  = op_a < op_b;

  always_comb begin
    case (op)
      OP_SUB:              result = diff;
      OP_SLT, OP_SLTI:     result = word_t'(lt_s);
      OP_SLTU, OP_SLTIU:   result = word_t'(lt_u);
      OP_AND, OP_ANDI:     result = op_a & op_b;
      OP_OR, OP_ORI:       result = op_a | op_b;
      OP_XOR, OP_XORI:     result = op_a ^ op_b;
      OP_SLL, OP_SLLI:     result = op_a << shamt;
      OP_SRL, OP_SRLI:     result = op_a >> shamt;
      OP_SRA, OP_SRAI:     result = word_t'($signed(op_a) >>> shamt);
      default:             result = sum;  // add, addi, lw/sw address
    endcase
  end

endmodule

/* alu/rv_branch.sv */
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_branch (
  input  rv_exec_pkg::exec_op_t op,
  input  rv_exec_pkg::word_t    pc,
  input  rv_exec_pkg::word_t    rs1_val,
  input  rv_exec_pkg::word_t    rs2_val,
  input  rv_exec_pkg::word_t    imm_ext,
  output rv_exec_pkg::word_t    pc_next,
  output rv_exec_pkg::word_t    link
);
  import rv_exec_pkg::*;

  word_t pc_rel;
  word_t jalr_tgt;
  logic  eq;
  logic  lt_s;
  logic  lt_u;
  logic  taken;

  assign eq   = rs1_val == rs2_val;
  assign lt_s = $signed(rs1_val) < $signed(rs2_val);
  assign lt_u = rs1_val < rs2_val;

  assign link     = pc + word_t'(`PC_STEP);
  assign pc_rel   = pc + imm_ext;
  assign jalr_tgt = (rs1_val + imm_ext) & ~word_t'(1);  // bit 0 cleared

  always_comb begin
    case (op)
      OP_BEQ:  taken = eq;
      OP_BNE:  taken = !eq;
      OP_BLT:  taken = lt_s;
      OP_BGE:  taken = !lt_s;
      OP_BLTU: taken = lt_u;
      OP_BGEU: taken = !lt_u;
      OP_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // jalr is register relative, everything else pc relative
  always_comb begin
    if (op == OP_JALR) begin
      pc_next = jalr_tgt;
    end else if (taken) begin
      pc_next = pc_rel;
    end else begin
      pc_next = link;
    end
  end

endmodule

/* lsu/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               write,
  input  rv_exec_pkg::word_t addr,
  input  rv_exec_pkg::word_t wdata,
  output logic               done,
  output rv_exec_pkg::word_t load_data,
  output logic               mem_req,
  output logic               mem_write,
  output rv_exec_pkg::word_t mem_addr,
  output rv_exec_pkg::word_t mem_wdata,
  input  logic               mem_ack,
  input  rv_exec_pkg::word_t mem_rdata
);
  import rv_exec_pkg::*;

  lsu_state_t state_q;
  lsu_state_t state_d;

  // ----------------------------------------
  // four-phase sequencing
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      LSU_IDLE: begin
        if (start) begin
          state_d = LSU_REQ;
        end
      end
      LSU_REQ: begin
        if (mem_ack) begin
          state_d = LSU_REL;  // drop req on the ack
        end
      end
      LSU_REL: begin
        if (!mem_ack) begin
          state_d = LSU_DONE;
        end
      end
      default: state_d = LSU_IDLE;  // done lasts one cycle
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= LSU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign mem_req = (state_q == LSU_REQ);
  assign done    = (state_q == LSU_DONE);

  // bus fields held from start until the next transfer
  always_ff @(posedge clk) begin
    if (state_q == LSU_IDLE && start) begin
      mem_write <= write;
      mem_addr  <= addr;
      mem_wdata <= wdata;
    end
  end

  // read data sampled with the ack
  always_ff @(posedge clk) begin
    if (state_q == LSU_REQ && mem_ack && !mem_write) begin
      load_data <= mem_rdata;
    end
  end

endmodule

/* source/rv_exec.sv */
`timescale 1ns/1ps

module rv_exec (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue_vld,
  input  rv_exec_pkg::exec_op_t op,
  input  rv_exec_pkg::reg_idx_t rd,
  input  rv_exec_pkg::word_t    rs1_val,
  input  rv_exec_pkg::word_t    rs2_val,
  input  rv_exec_pkg::word_t    imm,
  input  rv_exec_pkg::word_t    pc,
  output logic                  busy,
  output logic                  exec_vld,
  output logic                  rd_wr,
  output rv_exec_pkg::reg_idx_t rd_out,
  output rv_exec_pkg::word_t    rd_data,
  output rv_exec_pkg::word_t    pc_next,
  output logic                  pc_wr,
  output logic                  mem_req,
  output logic                  mem_write,
  output rv_exec_pkg::word_t    mem_addr,
  output rv_exec_pkg::word_t    mem_wdata,
  input  logic                  mem_ack,
  input  rv_exec_pkg::word_t    mem_rdata
);
  import rv_exec_pkg::*;

  word_t    imm_ext;
  word_t    op_b;
  word_t    alu_result;
  word_t    br_pc_next;
  word_t    link;
  word_t    load_data;
  word_t    res_sel;
  word_t    rd_data_q;
  exec_op_t op_q;
  logic     accept;
  logic     is_mem;
  logic     wr_sel;
  logic     lsu_done;
  logic     vld_q;
  logic     rd_wr_q;

  assign accept = issue_vld && !busy;
  assign is_mem = (op == OP_LW) || (op == OP_SW);

  rv_operand_sel u_operand_sel (
    .op      (op),
    .imm     (imm),
    .rs2_val (rs2_val),
    .imm_ext (imm_ext),
    .op_b    (op_b)
  );

  rv_alu u_alu (
    .op     (op),
    .op_a   (rs1_val),
    .op_b   (op_b),
    .result (alu_result)  // also the LW/SW address
  );

  rv_branch u_branch (
    .op      (op),
    .pc      (pc),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .imm_ext (imm_ext),
    .pc_next (br_pc_next),
    .link    (link)
  );

  rv_lsu u_lsu (
    .clk       (clk),
    .rst       (rst),
    .start     (accept && is_mem),
    .write     (op == OP_SW),
    .addr      (alu_result),
    .wdata     (rs2_val),
    .done      (lsu_done),
    .load_data (load_data),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  // ----------------------------------------
  // write-back selection
  // ----------------------------------------
  always_comb begin
    res_sel = alu_result;
    wr_sel  = 1'b1;
    case (op)
      OP_JAL, OP_JALR: res_sel = link;
      OP_LUI:          res_sel = imm;     // already shifted by decode
      OP_AUIPC:        res_sel = pc + imm;
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_SW: wr_sel = 1'b0;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      vld_q   <= 1'b0;
      rd_wr_q <= 1'b0;
    end else begin
      vld_q   <= accept && !is_mem;
      rd_wr_q <= accept && !is_mem && wr_sel;
      if (accept) begin
        busy <= 1'b1;
      end else if (exec_vld) begin
        busy <= 1'b0;  // free again after the result cycle
      end
    end
  end

  // latched instruction and registered results
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q      <= op;
      rd_out    <= rd;
      rd_data_q <= res_sel;
      pc_next   <= br_pc_next;  // pc + 4 for LW/SW
    end
  end

  // memory ops finish on the lsu done pulse
  assign exec_vld = vld_q || lsu_done;
  assign pc_wr    = exec_vld;
  assign rd_wr    = rd_wr_q || (lsu_done && (op_q == OP_LW));
  assign rd_data  = (op_q == OP_LW) ? load_data : rd_data_q;

endmodule

/* bench/rv_exec_checker.sv */
`timescale 1ns/1ps

module rv_exec_checker (
  input logic               clk,
  input logic               rst,
  input logic               issue_vld,
  input logic               exec_vld,
  input logic               mem_req,
  input logic               mem_ack,
  input logic               mem_write,
  input rv_exec_pkg::word_t mem_addr,
  input rv_exec_pkg::word_t mem_wdata
);

  // ----------------------------------------
  // data bus handshake
  // ----------------------------------------
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req && !mem_ack |=> mem_req)
    else $error("mem_req dropped before mem_ack");

  a_bus_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req && !mem_ack |=> $stable(mem_write) && $stable(mem_addr) && $stable(mem_wdata))
    else $error("bus fields changed while mem_req waited for mem_ack");

  // new request only after the ack is released
  a_req_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(mem_req) |-> !mem_ack)
    else $error("mem_req rose while mem_ack was still high");

  // result pulse
  a_vld_pulse: assert property (@(posedge clk) disable iff (rst)
    exec_vld |=> !exec_vld)
    else $error("exec_vld held for more than one cycle");

  a_vld_issue: assert property (@(posedge clk) disable iff (rst)
    !(exec_vld && issue_vld))
    else $error("exec_vld together with issue_vld");

endmodule

bind rv_exec rv_exec_checker u_checker (
  .clk       (clk),
  .rst       (rst),
  .issue_vld (issue_vld),
  .exec_vld  (exec_vld),
  .mem_req   (mem_req),
  .mem_ack   (mem_ack),
  .mem_write (mem_write),
  .mem_addr  (mem_addr),
  .mem_wdata (mem_wdata)
);

/* bench/rv_exec_tb.sv */
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_exec_tb;
  import rv_exec_pkg::*;

  localparam int WAIT_LIMIT = 64;
  localparam int MEM_WORDS  = 256;

  logic     clk;
  logic     rst;
  logic     issue_vld;
  exec_op_t op;
  reg_idx_t rd;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    imm;
  word_t    pc;
  logic     busy;
  logic     exec_vld;
  logic     rd_wr;
  reg_idx_t rd_out;
  word_t    rd_data;
  word_t    pc_next;
  logic     pc_wr;
  logic     mem_req;
  logic     mem_write;
  word_t    mem_addr;
  word_t    mem_wdata;
  logic     mem_ack;
  word_t    mem_rdata;

  int       cyc = 0;
  word_t    mem [MEM_WORDS];
  word_t    last_addr;   // what the memory model saw on its last ack
  word_t    last_wdata;
  logic     last_write;
  int       xfer_cnt = 0;

  // expected results, oldest first
  exec_op_t exp_op_q[$];
  reg_idx_t exp_rd_q[$];
  logic     exp_wr_q[$];
  word_t    exp_data_q[$];
  word_t    exp_pc_q[$];
  int       exp_cyc_q[$];

  exec_op_t alu_ops[19] = '{OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR,
                            OP_SLL, OP_SRL, OP_SRA, OP_ADDI, OP_SLTI, OP_SLTIU,
                            OP_ANDI, OP_ORI, OP_XORI, OP_SLLI, OP_SRLI, OP_SRAI};
  exec_op_t br_ops[6]   = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};

  rv_exec dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic fail_stop();
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_idx(string name, reg_idx_t got, reg_idx_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      fail_stop();
    end
  endtask

  function automatic word_t sext(word_t v, int bits);
    word_t sh;
    sh = v << (`XLEN - bits);
    return word_t'($signed(sh) >>> (`XLEN - bits));
  endfunction

  function automatic int mem_index(word_t a);
    return int'(a[9:2]);  // 256 words
  endfunction

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic void exec_ref(input exec_op_t o, input word_t a, input word_t b,
                                   input word_t i, input word_t p, input word_t mem_word,
                                   output logic wr, output word_t data, output word_t nxt);
    word_t ii;
    word_t seq;
    logic  take;
    ii   = sext(i, `IMM_I_W);
    seq  = p + `PC_STEP;
    wr   = 1'b1;
    data = '0;
    nxt  = seq;
    take = 1'b0;
    case (o)
      OP_ADD:   data = a + b;
      OP_SUB:   data = a - b;
      OP_SLT:   data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_SLTU:  data = (a < b) ? 32'd1 : 32'd0;
      OP_AND:   data = a & b;
      OP_OR:    data = a | b;
      OP_XOR:   data = a ^ b;
      OP_SLL:   data = a << b[`SHAMT_W-1:0];
      OP_SRL:   data = a >> b[`SHAMT_W-1:0];
      OP_SRA:   data = $signed(a) >>> b[`SHAMT_W-1:0];
      OP_ADDI:  data = a + ii;
      OP_SLTI:  data = ($signed(a) < $signed(ii)) ? 32'd1 : 32'd0;
      OP_SLTIU: data = (a < ii) ? 32'd1 : 32'd0;
      OP_ANDI:  data = a & ii;
      OP_ORI:   data = a | ii;
      OP_XORI:  data = a ^ ii;
      OP_SLLI:  data = a << ii[`SHAMT_W-1:0];
      OP_SRLI:  data = a >> ii[`SHAMT_W-1:0];
      OP_SRAI:  data = $signed(a) >>> ii[`SHAMT_W-1:0];
      OP_LUI:   data = i;
      OP_AUIPC: data = p + i;
      OP_JAL: begin
        data = seq;
        nxt  = p + sext(i, `IMM_J_W);
      end
      OP_JALR: begin
        data = seq;
        nxt  = (a + ii) & ~word_t'(1);
      end
      OP_BEQ:   take = (a == b);
      OP_BNE:   take = (a != b);
      OP_BLT:   take = ($signed(a) < $signed(b));
      OP_BGE:   take = ($signed(a) >= $signed(b));
      OP_BLTU:  take = (a < b);
      OP_BGEU:  take = (a >= b);
      OP_LW:    data = mem_word;
      default: ;
    endcase
    if (o inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_SW}) begin
      wr = 1'b0;
    end
    if (take) begin
      nxt = p + sext(i, `IMM_B_W);
    end
  endfunction

  // one issue pulse, then wait until busy is released
  task automatic issue_op(exec_op_t o, reg_idx_t d, word_t a, word_t b, word_t i, word_t p);
    logic  wr;
    word_t data;
    word_t nxt;
    int    cnt;
    exec_ref(o, a, b, i, p, mem[mem_index(a + sext(i, `IMM_I_W))], wr, data, nxt);
    exp_op_q.push_back(o);
    exp_rd_q.push_back(d);
    exp_wr_q.push_back(wr);
    exp_data_q.push_back(data);
    exp_pc_q.push_back(nxt);
    exp_cyc_q.push_back(cyc + 1);  // edge where the dut samples it
    issue_vld <= 1'b1;
    op        <= o;
    rd        <= d;
    rs1_val   <= a;
    rs2_val   <= b;
    imm       <= i;
    pc        <= p;
    @(posedge clk);
    issue_vld <= 1'b0;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        $display("busy never cleared after %s", o.name());
        fail_stop();
      end
    end while (busy);
  endtask

  task automatic mem_op(exec_op_t o, word_t a, word_t b, word_t i);
    int    cnt0;
    word_t addr;
    cnt0 = xfer_cnt;
    addr = a + sext(i, `IMM_I_W);
    issue_op(o, reg_idx_t'($urandom), a, b, i, word_t'($urandom) & ~word_t'(3));
    if (xfer_cnt != cnt0 + 1) begin
      $display("%s made %0d bus transfers instead of one", o.name(), xfer_cnt - cnt0);
      fail_stop();
    end
    check_word("mem_addr", last_addr, addr);
    check_bit("mem_write", last_write, o == OP_SW);
    if (o == OP_SW) begin
      check_word("mem_wdata", last_wdata, b);
    end
  endtask

  // ----------------------------------------
  // data bus memory model
  // ----------------------------------------
  initial begin : memory_model
    int cnt;
    mem_ack   <= 1'b0;
    mem_rdata <= '0;
    for (int k = 0; k < MEM_WORDS; k++) begin
      mem[k] = {8'(k), 8'(~k), 8'(k * 7), 8'(k ^ 8'h3c)};
    end
    forever begin
      @(posedge clk);
      if (!rst && mem_req && !mem_ack) begin
        repeat ($urandom_range(3, 0)) @(posedge clk);
        last_addr  = mem_addr;
        last_wdata = mem_wdata;
        last_write = mem_write;
        xfer_cnt++;
        if (mem_write) begin
          mem[mem_index(mem_addr)] = mem_wdata;
        end else begin
          mem_rdata <= mem[mem_index(mem_addr)];
        end
        mem_ack <= 1'b1;
        cnt = 0;
        do begin
          @(posedge clk);
          cnt++;
          if (cnt > WAIT_LIMIT) begin
            $display("mem_req was not released after mem_ack");
            fail_stop();
          end
        end while (mem_req);
        repeat ($urandom_range(3, 0)) @(posedge clk);  // slow ack release
        mem_ack <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // result compare
  // ----------------------------------------
  initial begin : compare_results
    int idle;
    idle = 0;
    forever begin
      @(posedge clk);
      if (rst) begin
        idle = 0;
      end else if (exp_op_q.size() == 0 || cyc <= exp_cyc_q[0]) begin
        if (exec_vld) begin
          $display("exec_vld came with no instruction outstanding");
          fail_stop();
        end
      end else begin
        check_bit("busy", busy, 1'b1);
        if (exec_vld) begin
          if (!(exp_op_q[0] inside {OP_LW, OP_SW}) && cyc != exp_cyc_q[0] + 1) begin
            $display("%s finished in cycle %0d instead of %0d", exp_op_q[0].name(), cyc,
                     exp_cyc_q[0] + 1);
            fail_stop();
          end
          check_bit("rd_wr", rd_wr, exp_wr_q[0]);
          if (exp_wr_q[0]) begin
            check_idx("rd_out", rd_out, exp_rd_q[0]);
            check_word("rd_data", rd_data, exp_data_q[0]);
          end
          check_bit("pc_wr", pc_wr, 1'b1);
          check_word("pc_next", pc_next, exp_pc_q[0]);
          void'(exp_op_q.pop_front());
          void'(exp_rd_q.pop_front());
          void'(exp_wr_q.pop_front());
          void'(exp_data_q.pop_front());
          void'(exp_pc_q.pop_front());
          void'(exp_cyc_q.pop_front());
          idle = 0;
        end else begin
          idle++;
          if (idle > WAIT_LIMIT) begin
            $display("timed out waiting for exec_vld of %s", exp_op_q[0].name());
            fail_stop();
          end
        end
      end
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin : stimulus
    word_t a;
    word_t b;
    void'($urandom(32'hb2d9_dcc9));
    rst       <= 1'b1;
    issue_vld <= 1'b0;
    op        <= OP_ADD;
    rd        <= '0;
    rs1_val   <= '0;
    rs2_val   <= '0;
    imm       <= '0;
    pc        <= '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_bit("exec_vld", exec_vld, 1'b0);
    check_bit("rd_wr", rd_wr, 1'b0);
    check_bit("pc_wr", pc_wr, 1'b0);
    check_bit("mem_req", mem_req, 1'b0);
    check_bit("busy", busy, 1'b0);

    issue_op(OP_ADDI, 5'd3, 32'h0000_0010, 32'h0, 32'h0000_0ff0, 32'h0000_0400);  // imm -16
    issue_op(OP_SRA, 5'd4, 32'h8000_0f00, 32'h0000_0024, 32'h0, 32'h0000_0404);
    issue_op(OP_SLL, 5'd5, 32'h0000_0003, 32'hffff_ffe1, 32'h0, 32'h0000_0408);
    for (int k = 0; k < 300; k++) begin
      issue_op(alu_ops[$urandom_range(18, 0)], reg_idx_t'($urandom), $urandom, $urandom,
               $urandom, word_t'($urandom) & ~word_t'(3));
      repeat ($urandom_range(2, 0)) @(posedge clk);
    end

    // branches, jumps and upper immediates
    issue_op(OP_BLT, 5'd0, 32'hffff_fff0, 32'h0000_0010, 32'h0000_0020, 32'h0000_1000);
    issue_op(OP_BLTU, 5'd0, 32'hffff_fff0, 32'h0000_0010, 32'h0000_0020, 32'h0000_1000);
    issue_op(OP_JALR, 5'd1, 32'h0000_1001, 32'h0, 32'h0000_0004, 32'h0000_2000);
    for (int k = 0; k < 120; k++) begin
      a = $urandom;
      b = ($urandom_range(1, 0) != 0) ? a : word_t'($urandom);
      issue_op(br_ops[$urandom_range(5, 0)], reg_idx_t'($urandom), a, b,
               word_t'($urandom) & 32'h0000_1ffe, word_t'($urandom) & ~word_t'(3));
    end
    for (int k = 0; k < 60; k++) begin
      issue_op(OP_JAL, reg_idx_t'($urandom), $urandom, $urandom,
               word_t'($urandom) & 32'h001f_fffe, word_t'($urandom) & ~word_t'(3));
      issue_op(OP_JALR, reg_idx_t'($urandom), $urandom, $urandom, $urandom,
               word_t'($urandom) & ~word_t'(3));
      issue_op(OP_LUI, reg_idx_t'($urandom), $urandom, $urandom,
               word_t'($urandom) & 32'hffff_f000, word_t'($urandom) & ~word_t'(3));
      issue_op(OP_AUIPC, reg_idx_t'($urandom), $urandom, $urandom,
               word_t'($urandom) & 32'hffff_f000, word_t'($urandom) & ~word_t'(3));
    end

    // store then load back through the bus
    mem_op(OP_SW, 32'h0000_0180, 32'hc3a5_5a3c, 32'h0000_0ff8);
    mem_op(OP_LW, 32'h0000_0180, 32'h0, 32'h0000_0ff8);
    for (int k = 0; k < 80; k++) begin
      a = 32'h0000_0100 + ($urandom_range(63, 0) * 4);
      b = ($urandom_range(32, 0) * 4) - 64;
      mem_op(($urandom_range(1, 0) != 0) ? OP_SW : OP_LW, a, $urandom, b);
      repeat ($urandom_range(2, 0)) @(posedge clk);
    end

    repeat (2) @(posedge clk);
    if (exp_op_q.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("%0d results never arrived", exp_op_q.size());
      fail_stop();
    end
  end

endmodule

/* rv_exec.f */
+incdir+common
common/rv_exec_pkg.sv
source/rv_operand_sel.sv
alu/rv_alu.sv
alu/rv_branch.sv
lsu/rv_lsu.sv
source/rv_exec.sv
bench/rv_exec_checker.sv
bench/rv_exec_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = rv_exec_tb
RTL_TOP  = rv_exec
FILELIST = rv_exec.f
OBJ_DIR  = obj_dir
PASS_MSG = TB PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
